/* Bender.yml */
package:
  name: fsab_memory

sources:
  - fsab_mem_pkg.sv
  - fsab_fifo.sv
  - fsab_mem_ifs.sv
  - fsab_req_intake.sv
  - read_slot_credits.sv
  - mig_cmd_issue.sv
  - fsab_resp_path.sv
  - fsab_memory.sv
  - target: test
    files:
      - tb_fsab_memory_asserts.sv
      - tb_fsab_memory.sv

/* fsab_fifo.sv */
// Circular-buffer FIFO with registered read data; instantiated for every queue of the bridge
`timescale 1ns/1ps

module fsab_fifo #(
	parameter int WIDTH = 8,
	parameter int DEPTH = 4
) (
	input  logic clk0_tb,
	input  logic rst0_tb,
	input  logic wr_en,
	input  logic [WIDTH-1:0] wr_data,
	input  logic rd_en,
	output logic [WIDTH-1:0] rd_data,
	output logic empty,
	output logic [$clog2(DEPTH+1)-1:0] count
);
	logic [WIDTH-1:0] mem [DEPTH];
	logic [$clog2(DEPTH)-1:0] wr_ptr;
	logic [$clog2(DEPTH)-1:0] rd_ptr;

	assign empty = (count == '0);

	always_ff @(posedge clk0_tb or posedge rst0_tb) begin
		if (rst0_tb) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (wr_en)
				wr_ptr <= (wr_ptr == DEPTH - 1) ? '0 : wr_ptr + 1'b1;
			if (rd_en)
				rd_ptr <= (rd_ptr == DEPTH - 1) ? '0 : rd_ptr + 1'b1;
			case ({wr_en, rd_en})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	always_ff @(posedge clk0_tb) begin
		if (wr_en)
			mem[wr_ptr] <= wr_data;
		if (rd_en)
			rd_data <= mem[rd_ptr];    // Valid the cycle after the pop
	end

endmodule

/* fsab_mem_ifs.sv */
// Internal links of the bridge: request queue to issuer, issuer to response path
`timescale 1ns/1ps

interface req_q_if;
	import fsab_mem_pkg::*;

	logic req_ready;                    // Header and all its words queued
	logic [FSAB_MODE_W-1:0] req_mode;
	logic [FSAB_DID_W-1:0] req_did;
	logic [FSAB_DID_W-1:0] req_subdid;
	logic [FSAB_ADDR_W-1:0] req_addr;
	logic [FSAB_LEN_W-1:0] req_len;
	logic [APP_DATA_W-1:0] wdata;
	logic [APP_MASK_W-1:0] wmask;       // FSAB polarity
	logic req_pop;
	logic wdata_pop;

	modport intake (output req_ready, req_mode, req_did, req_subdid, req_addr, req_len,
		wdata, wmask, input req_pop, wdata_pop);
	modport issue (input req_ready, req_mode, req_did, req_subdid, req_addr, req_len,
		wdata, wmask, output req_pop, wdata_pop);
endinterface

interface rtag_if;
	import fsab_mem_pkg::*;

	logic tag_push;
	logic [FSAB_DID_W-1:0] tag_did;
	logic [FSAB_DID_W-1:0] tag_subdid;
	logic [FSAB_LEN_W-1:0] tag_len;
	logic slot_free;                    // Response slot handed back

	modport issue (output tag_push, tag_did, tag_subdid, tag_len, input slot_free);
	modport response (input tag_push, tag_did, tag_subdid, tag_len, output slot_free);
endinterface

/* fsab_mem_pkg.sv */
// Shared widths, codes, depths and state encodings for the FSAB to DDR2 bridge; import where needed
package fsab_mem_pkg;

	// FSAB side
	localparam int FSAB_DATA_W = 64;
	localparam int FSAB_MASK_W = 8;          // 1 = byte written
	localparam int FSAB_ADDR_W = 31;
	localparam int FSAB_DID_W = 4;
	localparam int FSAB_LEN_W = 4;
	localparam int FSAB_LEN_MAX = 8;
	localparam int FSAB_MODE_W = 1;
	localparam logic [FSAB_MODE_W-1:0] FSAB_MODE_READ = 1'b0;
	localparam logic [FSAB_MODE_W-1:0] FSAB_MODE_WRITE = 1'b1;
	localparam int FSAB_INITIAL_CREDITS = 4;

	// Controller application port
	localparam int APP_DATA_W = 128;         // Two FSAB beats
	localparam int APP_MASK_W = 16;          // 1 = byte masked
	localparam int MIG_CMD_W = 3;
	localparam logic [MIG_CMD_W-1:0] MIG_CMD_WRITE = 3'd0;
	localparam logic [MIG_CMD_W-1:0] MIG_CMD_READ = 3'd1;
	localparam int MIG_WORDS_PER_BURST = 2;
	localparam int MIG_BURST_BYTES = 32;

	// Queue sizing
	localparam int RESP_SLOTS = 4;
	localparam int REQ_FIFO_DEPTH = FSAB_INITIAL_CREDITS;
	localparam int WDATA_FIFO_DEPTH = FSAB_INITIAL_CREDITS * 4;
	localparam int RDATA_FIFO_DEPTH = RESP_SLOTS * 4;

	// Queue entry widths and counters
	localparam int REQ_HDR_W = FSAB_MODE_W + 2 * FSAB_DID_W + FSAB_ADDR_W + FSAB_LEN_W;
	localparam int WQ_W = APP_DATA_W + APP_MASK_W;
	localparam int TAG_W = 2 * FSAB_DID_W + FSAB_LEN_W;
	localparam int REQ_CNT_W = $clog2(FSAB_INITIAL_CREDITS + 1);
	localparam int SLOT_CNT_W = $clog2(RESP_SLOTS + 1);
	localparam int RDATA_CNT_W = $clog2(RDATA_FIFO_DEPTH + 1);

	// FSM encodings
	localparam int ST_W = 2;
	localparam logic [ST_W-1:0] ST_IDLE = 2'd0;
	localparam logic [ST_W-1:0] ST_CMD = 2'd1;
	localparam logic [ST_W-1:0] ST_WORDS = 2'd2;
	localparam logic [ST_W-1:0] RS_IDLE = 2'd0;
	localparam logic [ST_W-1:0] RS_WAIT = 2'd1;
	localparam logic [ST_W-1:0] RS_SEND = 2'd2;
	localparam logic [ST_W-1:0] RS_DRAIN = 2'd3;

endpackage

/* fsab_memory.f */
fsab_mem_pkg.sv
fsab_fifo.sv
fsab_mem_ifs.sv
fsab_req_intake.sv
read_slot_credits.sv
mig_cmd_issue.sv
fsab_resp_path.sv
fsab_memory.sv
tb_fsab_memory_asserts.sv
tb_fsab_memory.sv

/* fsab_memory.sv */
// Top of the FSAB to DDR2 application-port bridge; FSAB ports on one side, controller on the other
`timescale 1ns/1ps

module fsab_memory (
	input  logic clk0_tb,
	input  logic rst0_tb,
	input  logic fsabo_valid,
	input  logic [fsab_mem_pkg::FSAB_MODE_W-1:0] fsabo_mode,
	input  logic [fsab_mem_pkg::FSAB_DID_W-1:0] fsabo_did,
	input  logic [fsab_mem_pkg::FSAB_DID_W-1:0] fsabo_subdid,
	input  logic [fsab_mem_pkg::FSAB_ADDR_W-1:0] fsabo_addr,
	input  logic [fsab_mem_pkg::FSAB_LEN_W-1:0] fsabo_len,
	input  logic [fsab_mem_pkg::FSAB_DATA_W-1:0] fsabo_data,
	input  logic [fsab_mem_pkg::FSAB_MASK_W-1:0] fsabo_mask,
	output logic fsabo_credit,
	output logic fsabi_valid,
	output logic [fsab_mem_pkg::FSAB_DID_W-1:0] fsabi_did,
	output logic [fsab_mem_pkg::FSAB_DID_W-1:0] fsabi_subdid,
	output logic [fsab_mem_pkg::FSAB_DATA_W-1:0] fsabi_data,
	output logic app_af_wren,
	output logic [fsab_mem_pkg::MIG_CMD_W-1:0] app_af_cmd,
	output logic [fsab_mem_pkg::FSAB_ADDR_W-1:0] app_af_addr,
	output logic app_wdf_wren,
	output logic [fsab_mem_pkg::APP_DATA_W-1:0] app_wdf_data,
	output logic [fsab_mem_pkg::APP_MASK_W-1:0] app_wdf_mask_data,
	input  logic app_af_afull,
	input  logic app_wdf_afull,
	input  logic rd_data_valid,
	input  logic [fsab_mem_pkg::APP_DATA_W-1:0] rd_data_fifo_out,
	input  logic phy_init_done
);
	req_q_if req_q ();
	rtag_if rtag ();

	fsab_req_intake fsab_req_intake_inst (
		.clk0_tb      (clk0_tb),
		.rst0_tb      (rst0_tb),
		.fsabo_valid  (fsabo_valid),
		.fsabo_mode   (fsabo_mode),
		.fsabo_did    (fsabo_did),
		.fsabo_subdid (fsabo_subdid),
		.fsabo_addr   (fsabo_addr),
		.fsabo_len    (fsabo_len),
		.fsabo_data   (fsabo_data),
		.fsabo_mask   (fsabo_mask),
		.q            (req_q.intake)
	);

	mig_cmd_issue mig_cmd_issue_inst (
		.clk0_tb           (clk0_tb),
		.rst0_tb           (rst0_tb),
		.phy_init_done     (phy_init_done),
		.app_af_afull      (app_af_afull),
		.app_wdf_afull     (app_wdf_afull),
		.q                 (req_q.issue),
		.t                 (rtag.issue),
		.app_af_wren       (app_af_wren),
		.app_af_cmd        (app_af_cmd),
		.app_af_addr       (app_af_addr),
		.app_wdf_wren      (app_wdf_wren),
		.app_wdf_data      (app_wdf_data),
		.app_wdf_mask_data (app_wdf_mask_data),
		.fsabo_credit      (fsabo_credit)
	);

	fsab_resp_path fsab_resp_path_inst (
		.clk0_tb          (clk0_tb),
		.rst0_tb          (rst0_tb),
		.rd_data_valid    (rd_data_valid),
		.rd_data_fifo_out (rd_data_fifo_out),
		.t                (rtag.response),
		.fsabi_valid      (fsabi_valid),
		.fsabi_did        (fsabi_did),
		.fsabi_subdid     (fsabi_subdid),
		.fsabi_data       (fsabi_data)
	);

endmodule

/* fsab_req_intake.sv */
// FSAB request intake; queues headers and packs write beats in pairs into controller words
`timescale 1ns/1ps

module fsab_req_intake (
	input  logic clk0_tb,
	input  logic rst0_tb,
	input  logic fsabo_valid,
	input  logic [fsab_mem_pkg::FSAB_MODE_W-1:0] fsabo_mode,
	input  logic [fsab_mem_pkg::FSAB_DID_W-1:0] fsabo_did,
	input  logic [fsab_mem_pkg::FSAB_DID_W-1:0] fsabo_subdid,
	input  logic [fsab_mem_pkg::FSAB_ADDR_W-1:0] fsabo_addr,
	input  logic [fsab_mem_pkg::FSAB_LEN_W-1:0] fsabo_len,
	input  logic [fsab_mem_pkg::FSAB_DATA_W-1:0] fsabo_data,
	input  logic [fsab_mem_pkg::FSAB_MASK_W-1:0] fsabo_mask,
	req_q_if.intake q
);
	import fsab_mem_pkg::*;

	logic [FSAB_LEN_W-1:0] rem;         // Write beats still to come
	logic have_half;                    // Even beat waiting for its partner
	logic [FSAB_DATA_W-1:0] held_data;
	logic [FSAB_MASK_W-1:0] held_mask;
	logic [REQ_CNT_W-1:0] ready_cnt;    // Fully queued requests
	logic new_req;
	logic wr_beat;
	logic last_beat;
	logic req_done;
	logic word_push;
	logic [WQ_W-1:0] word;
	logic [REQ_HDR_W-1:0] hdr_out;
	logic [WQ_W-1:0] word_out;

	assign new_req = fsabo_valid && (rem == '0);
	assign wr_beat = fsabo_valid && ((rem != '0) || (fsabo_mode == FSAB_MODE_WRITE));
	assign last_beat = wr_beat && (new_req ? (fsabo_len == 1) : (rem == 1));
	assign req_done = (new_req && fsabo_mode == FSAB_MODE_READ) || last_beat;
	assign word_push = wr_beat && (have_half || last_beat);

	// Even beat in the low half, odd beat in the high half
	assign word = have_half ? {fsabo_data, held_data, fsabo_mask, held_mask}
		: {{FSAB_DATA_W{1'b0}}, fsabo_data, {FSAB_MASK_W{1'b0}}, fsabo_mask};

	assign {q.req_mode, q.req_did, q.req_subdid, q.req_addr, q.req_len} = hdr_out;
	assign {q.wdata, q.wmask} = word_out;
	assign q.req_ready = (ready_cnt != '0);

	always_ff @(posedge clk0_tb or posedge rst0_tb) begin
		if (rst0_tb) begin
			rem <= '0;
			have_half <= 1'b0;
			ready_cnt <= '0;
		end else begin
			if (new_req && fsabo_mode == FSAB_MODE_WRITE)
				rem <= fsabo_len - 1'b1;
			else if (wr_beat)
				rem <= rem - 1'b1;
			if (wr_beat)
				have_half <= !have_half && !last_beat;
			if (req_done && !q.req_pop)
				ready_cnt <= ready_cnt + 1'b1;
			else if (!req_done && q.req_pop)
				ready_cnt <= ready_cnt - 1'b1;
		end
	end

	always_ff @(posedge clk0_tb) begin
		if (wr_beat && !have_half) begin
			held_data <= fsabo_data;
			held_mask <= fsabo_mask;
		end
	end

	fsab_fifo #(.WIDTH(REQ_HDR_W), .DEPTH(REQ_FIFO_DEPTH)) hdr_fifo_inst (
		.clk0_tb (clk0_tb),
		.rst0_tb (rst0_tb),
		.wr_en   (new_req),
		.wr_data ({fsabo_mode, fsabo_did, fsabo_subdid, fsabo_addr, fsabo_len}),
		.rd_en   (q.req_pop),
		.rd_data (hdr_out),
		.empty   (),
		.count   ()
	);

	fsab_fifo #(.WIDTH(WQ_W), .DEPTH(WDATA_FIFO_DEPTH)) wdata_fifo_inst (
		.clk0_tb (clk0_tb),
		.rst0_tb (rst0_tb),
		.wr_en   (word_push),
		.wr_data (word),
		.rd_en   (q.wdata_pop),
		.rd_data (word_out),
		.empty   (),
		.count   ()
	);

endmodule

/* fsab_resp_path.sv */
// Read response path; matches read tags with controller words and plays beats onto the FSAB return
`timescale 1ns/1ps

module fsab_resp_path (
	input  logic clk0_tb,
	input  logic rst0_tb,
	input  logic rd_data_valid,
	input  logic [fsab_mem_pkg::APP_DATA_W-1:0] rd_data_fifo_out,
	rtag_if.response t,
	output logic fsabi_valid,
	output logic [fsab_mem_pkg::FSAB_DID_W-1:0] fsabi_did,
	output logic [fsab_mem_pkg::FSAB_DID_W-1:0] fsabi_subdid,
	output logic [fsab_mem_pkg::FSAB_DATA_W-1:0] fsabi_data
);
	import fsab_mem_pkg::*;

	logic [ST_W-1:0] state;
	logic [FSAB_LEN_W-1:0] beat;
	logic [TAG_W-1:0] tag_out;
	logic [FSAB_LEN_W-1:0] tag_len;
	logic [FSAB_LEN_W:0] used;          // Words the response consumes
	logic [APP_DATA_W-1:0] word;
	logic [RDATA_CNT_W-1:0] word_cnt;
	logic tag_empty;
	logic word_empty;
	logic tag_pop;
	logic word_pop;
	logic last_beat;

	assign {fsabi_did, fsabi_subdid, tag_len} = tag_out;
	assign used = ({1'b0, tag_len} + 1'b1) >> 1;
	assign last_beat = (beat + 1'b1 == tag_len);

	assign tag_pop = (state == RS_IDLE) && !tag_empty;
	assign word_pop = ((state == RS_WAIT) && (word_cnt >= used))
		|| ((state == RS_SEND) && beat[0] && !last_beat)
		|| ((state == RS_DRAIN) && !word_empty);   // Leftover word of a burst

	assign fsabi_valid = (state == RS_SEND);
	assign fsabi_data = beat[0] ? word[APP_DATA_W-1:FSAB_DATA_W] : word[FSAB_DATA_W-1:0];

	// Odd word count leaves one unused word in the last burst
	assign t.slot_free = ((state == RS_SEND) && last_beat && !used[0])
		|| ((state == RS_DRAIN) && !word_empty);

	always_ff @(posedge clk0_tb or posedge rst0_tb) begin
		if (rst0_tb) begin
			state <= RS_IDLE;
			beat <= '0;
		end else begin
			case (state)
				RS_IDLE: begin
					if (tag_pop)
						state <= RS_WAIT;
				end
				RS_WAIT: begin
					if (word_pop) begin
						state <= RS_SEND;
						beat <= '0;
					end
				end
				RS_SEND: begin
					if (last_beat)
						state <= used[0] ? RS_DRAIN : RS_IDLE;
					else
						beat <= beat + 1'b1;
				end
				default: begin
					if (!word_empty)
						state <= RS_IDLE;
				end
			endcase
		end
	end

	fsab_fifo #(.WIDTH(TAG_W), .DEPTH(RESP_SLOTS)) tag_fifo_inst (
		.clk0_tb (clk0_tb),
		.rst0_tb (rst0_tb),
		.wr_en   (t.tag_push),
		.wr_data ({t.tag_did, t.tag_subdid, t.tag_len}),
		.rd_en   (tag_pop),
		.rd_data (tag_out),
		.empty   (tag_empty),
		.count   ()
	);

	fsab_fifo #(.WIDTH(APP_DATA_W), .DEPTH(RDATA_FIFO_DEPTH)) rdata_fifo_inst (
		.clk0_tb (clk0_tb),
		.rst0_tb (rst0_tb),
		.wr_en   (rd_data_valid),
		.wr_data (rd_data_fifo_out),
		.rd_en   (word_pop),
		.rd_data (word),
		.empty   (word_empty),
		.count   (word_cnt)
	);

endmodule

/* mig_cmd_issue.sv */
// Command issuer; turns queued requests into controller commands, write words and FSAB credits
`timescale 1ns/1ps

module mig_cmd_issue (
	input  logic clk0_tb,
	input  logic rst0_tb,
	input  logic phy_init_done,
	input  logic app_af_afull,
	input  logic app_wdf_afull,
	req_q_if.issue q,
	rtag_if.issue t,
	output logic app_af_wren,
	output logic [fsab_mem_pkg::MIG_CMD_W-1:0] app_af_cmd,
	output logic [fsab_mem_pkg::FSAB_ADDR_W-1:0] app_af_addr,
	output logic app_wdf_wren,
	output logic [fsab_mem_pkg::APP_DATA_W-1:0] app_wdf_data,
	output logic [fsab_mem_pkg::APP_MASK_W-1:0] app_wdf_mask_data,
	output logic fsabo_credit
);
	import fsab_mem_pkg::*;

	logic [ST_W-1:0] state;
	logic [FSAB_LEN_W-1:0] burst_idx;   // Burst within the request
	logic wib;                          // Word within the burst
	logic [FSAB_LEN_W:0] nwords;
	logic [FSAB_LEN_W:0] nbursts;
	logic is_write;
	logic slots_avail;
	logic last_burst;
	logic cmd_go;
	logic word_go;
	logic wr_done;

	assign is_write = (q.req_mode == FSAB_MODE_WRITE);
	assign nwords = ({1'b0, q.req_len} + 1'b1) >> 1;
	assign nbursts = (nwords + 1'b1) >> 1;
	assign last_burst = (burst_idx + 1'b1 == nbursts);

	assign cmd_go = (state == ST_CMD) && phy_init_done && !app_af_afull
		&& (is_write || slots_avail);
	assign word_go = (state == ST_WORDS) && !app_wdf_afull;

	assign app_af_wren = cmd_go;
	assign app_af_cmd = is_write ? MIG_CMD_WRITE : MIG_CMD_READ;
	assign app_af_addr = q.req_addr + FSAB_ADDR_W'(burst_idx) * FSAB_ADDR_W'(MIG_BURST_BYTES);
	assign app_wdf_wren = word_go;
	assign app_wdf_data = q.wdata;
	assign app_wdf_mask_data = ({burst_idx, wib} < nwords) ? ~q.wmask : '1;  // Pad words masked

	assign q.req_pop = (state == ST_IDLE) && q.req_ready && phy_init_done;
	// Next word fetched one cycle ahead of its wren
	assign q.wdata_pop = (cmd_go && is_write && ({burst_idx, 1'b0} < nwords))
		|| (word_go && !wib && ({burst_idx, 1'b1} < nwords));

	assign t.tag_push = cmd_go && !is_write && (burst_idx == '0);
	assign t.tag_did = q.req_did;
	assign t.tag_subdid = q.req_subdid;
	assign t.tag_len = q.req_len;

	assign fsabo_credit = wr_done || t.tag_push;

	always_ff @(posedge clk0_tb or posedge rst0_tb) begin
		if (rst0_tb) begin
			state <= ST_IDLE;
			burst_idx <= '0;
			wib <= 1'b0;
			wr_done <= 1'b0;
		end else begin
			wr_done <= word_go && wib && last_burst;
			case (state)
				ST_IDLE: begin
					if (q.req_pop) begin
						state <= ST_CMD;
						burst_idx <= '0;
						wib <= 1'b0;
					end
				end
				ST_CMD: begin
					if (cmd_go) begin
						if (is_write)
							state <= ST_WORDS;
						else if (last_burst)
							state <= ST_IDLE;
						else
							burst_idx <= burst_idx + 1'b1;
					end
				end
				ST_WORDS: begin
					if (word_go) begin
						wib <= !wib;
						if (wib) begin
							burst_idx <= burst_idx + 1'b1;
							state <= last_burst ? ST_IDLE : ST_CMD;
						end
					end
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	read_slot_credits read_slot_credits_inst (
		.clk0_tb     (clk0_tb),
		.rst0_tb     (rst0_tb),
		.debit       (t.tag_push),
		.credit      (t.slot_free),
		.slots_avail (slots_avail)
	);

endmodule

/* read_slot_credits.sv */
// Count of free read-response slots; gates read commands in the issuer
`timescale 1ns/1ps

module read_slot_credits (
	input  logic clk0_tb,
	input  logic rst0_tb,
	input  logic debit,                 // Read issued
	input  logic credit,                // Response slot released
	output logic slots_avail
);
	import fsab_mem_pkg::*;

	logic [SLOT_CNT_W-1:0] slots;

	assign slots_avail = (slots != '0);

	always_ff @(posedge clk0_tb or posedge rst0_tb) begin
		if (rst0_tb) begin
			slots <= SLOT_CNT_W'(RESP_SLOTS);
		end else begin
			case ({debit, credit})
				2'b10: slots <= slots - 1'b1;
				2'b01: slots <= slots + 1'b1;
				default: slots <= slots;
			endcase
		end
	end

endmodule

/* tb_fsab_memory.sv */
// Directed testbench for the FSAB to DDR2 bridge with an inline controller model; simulation top
`timescale 1ns/1ps

module tb_fsab_memory;
	import fsab_mem_pkg::*;

	localparam int WAIT_LIMIT = 3000;   // Cycles per wait loop

	logic clk0_tb;
	logic rst0_tb;
	logic fsabo_valid;
	logic [FSAB_MODE_W-1:0] fsabo_mode;
	logic [FSAB_DID_W-1:0] fsabo_did;
	logic [FSAB_DID_W-1:0] fsabo_subdid;
	logic [FSAB_ADDR_W-1:0] fsabo_addr;
	logic [FSAB_LEN_W-1:0] fsabo_len;
	logic [FSAB_DATA_W-1:0] fsabo_data;
	logic [FSAB_MASK_W-1:0] fsabo_mask;
	logic fsabo_credit;
	logic fsabi_valid;
	logic [FSAB_DID_W-1:0] fsabi_did;
	logic [FSAB_DID_W-1:0] fsabi_subdid;
	logic [FSAB_DATA_W-1:0] fsabi_data;
	logic app_af_wren;
	logic [MIG_CMD_W-1:0] app_af_cmd;
	logic [FSAB_ADDR_W-1:0] app_af_addr;
	logic app_wdf_wren;
	logic [APP_DATA_W-1:0] app_wdf_data;
	logic [APP_MASK_W-1:0] app_wdf_mask_data;
	logic app_af_afull;
	logic app_wdf_afull;
	logic rd_data_valid;
	logic [APP_DATA_W-1:0] rd_data_fifo_out;
	logic phy_init_done;

	byte unsigned ctl_mem [int];        // Controller model contents
	byte unsigned ref_mem [int];        // Expected contents, FSAB view
	int wr_addr_q [$];                  // Word addresses of accepted write commands
	int wr_head;
	int rd_addr_q [$];
	int rd_due_q [$];
	int rd_head;
	int rd_word;
	int rd_bursts_q [$];                // Commands per read, in request order
	int rd_cmd_head;
	int rd_cmd_in;
	int reads_started;
	int reads_done;
	logic [FSAB_DID_W-1:0] exp_did_q [$];
	logic [FSAB_DID_W-1:0] exp_subdid_q [$];
	logic [FSAB_DATA_W-1:0] exp_data_q [$];
	bit exp_first_q [$];
	int exp_head;
	int cyc;
	int sent;
	int credit_pulses;
	int cmd_count;
	int word_addr;
	bit prev_valid;
	bit stall_en;
	int data_errors;
	int proto_errors;
	int timeouts;

	fsab_memory fsab_memory_inst (.*);

	initial begin
		clk0_tb = 1'b0;
		forever #2 clk0_tb = ~clk0_tb;
	end

	function automatic byte unsigned fill_byte(input int a);
		return 8'(a ^ (a >> 8) ^ (a >> 16) ^ (a >> 24) ^ 8'h5a);
	endfunction

	function automatic byte unsigned ctl_byte(input int a);
		if (ctl_mem.exists(a))
			return ctl_mem[a];
		return fill_byte(a);
	endfunction

	function automatic byte unsigned ref_byte(input int a);
		if (ref_mem.exists(a))
			return ref_mem[a];
		return fill_byte(a);
	endfunction

	function automatic int credits_free();
		return FSAB_INITIAL_CREDITS - sent + credit_pulses;
	endfunction

	// Controller model and FSAB monitors sampled ahead of the DUT's edge updates
	always @(posedge clk0_tb) begin
		cyc++;
		if (fsabo_credit) begin
			credit_pulses++;
			if (credit_pulses > sent) begin
				proto_errors++;
				$display("Credit returned for a request that was never sent");
			end
		end
		if (app_af_wren) begin
			cmd_count++;
			if (!phy_init_done || app_af_afull) begin
				proto_errors++;
				$display("Command issued before init or while the command FIFO was full");
			end
			if (app_af_cmd == MIG_CMD_WRITE) begin
				wr_addr_q.push_back(int'(app_af_addr));
				wr_addr_q.push_back(int'(app_af_addr) + 16);
			end else begin
				rd_addr_q.push_back(int'(app_af_addr));
				rd_due_q.push_back(cyc + 3 + $urandom_range(5));  // 3 to 8 cycles
				rd_cmd_in++;
				if (rd_cmd_in == 1) begin       // First command of a read takes a slot
					reads_started++;
					if (reads_started - reads_done > RESP_SLOTS) begin
						proto_errors++;
						$display("More reads in flight than response slots");
					end
				end
				if (rd_cmd_head < rd_bursts_q.size() && rd_cmd_in == rd_bursts_q[rd_cmd_head]) begin
					rd_cmd_head++;
					rd_cmd_in = 0;
				end
			end
		end
		if (app_wdf_wren) begin
			if (app_wdf_afull || wr_head >= wr_addr_q.size()) begin
				proto_errors++;
				$display("Write word issued while full or without a write command");
			end else begin
				word_addr = wr_addr_q[wr_head];
				wr_head++;
				for (int i = 0; i < APP_MASK_W; i++)
					if (!app_wdf_mask_data[i])      // 1 means masked
						ctl_mem[word_addr + i] = app_wdf_data[8*i +: 8];
			end
		end
		if (fsabi_valid) begin
			if (exp_head >= exp_data_q.size()) begin
				proto_errors++;
				$display("Read response beat arrived with no read outstanding");
			end else begin
				if (exp_first_q[exp_head] == prev_valid) begin
					proto_errors++;
					$display("Read response beats were not exactly len consecutive cycles");
				end
				if (fsabi_did != exp_did_q[exp_head] || fsabi_subdid != exp_subdid_q[exp_head]
						|| fsabi_data != exp_data_q[exp_head]) begin
					data_errors++;
					$display("Error at %0t: beat did %0h subdid %0h data %h, expected %0h %0h %h",
						$time, fsabi_did, fsabi_subdid, fsabi_data, exp_did_q[exp_head],
						exp_subdid_q[exp_head], exp_data_q[exp_head]);
				end
				if (exp_head + 1 == exp_data_q.size() || exp_first_q[exp_head + 1])
					reads_done++;
				exp_head++;
			end
		end
		prev_valid = fsabi_valid;
	end

	// Read answers and back-pressure levels driven on the falling edge
	always @(negedge clk0_tb) begin
		rd_data_valid = 1'b0;
		if (stall_en && $urandom_range(3) == 0)
			app_af_afull = ~app_af_afull;
		if (stall_en && $urandom_range(3) == 0)
			app_wdf_afull = ~app_wdf_afull;
		if (!stall_en) begin
			app_af_afull = 1'b0;
			app_wdf_afull = 1'b0;
		end
		if (rd_head < rd_addr_q.size() && cyc >= rd_due_q[rd_head]) begin
			rd_data_valid = 1'b1;
			for (int i = 0; i < APP_MASK_W; i++)
				rd_data_fifo_out[8*i +: 8] = ctl_byte(rd_addr_q[rd_head] + 16 * rd_word + i);
			rd_word = (rd_word + 1) % MIG_WORDS_PER_BURST;
			if (rd_word == 0)
				rd_head++;
		end
	end

	task automatic wait_credit();
		int n;
		n = 0;
		while (credits_free() == 0 && n < WAIT_LIMIT) begin
			@(negedge clk0_tb);
			n++;
		end
		if (credits_free() == 0) begin
			timeouts++;
			$display("Timed out waiting for a request credit");
		end
	endtask

	task automatic send_write(input int addr, input int len, input bit partial);
		logic [FSAB_DATA_W-1:0] d;
		logic [FSAB_MASK_W-1:0] m;
		wait_credit();
		sent++;
		for (int k = 0; k < len; k++) begin
			if (k > 0 && $urandom_range(3) == 0) begin  // Occasional gap between beats
				fsabo_valid = 1'b0;
				@(negedge clk0_tb);
			end
			d = {$urandom, $urandom};
			m = partial ? FSAB_MASK_W'($urandom) : '1;
			fsabo_valid = 1'b1;
			fsabo_mode = FSAB_MODE_WRITE;
			fsabo_did = 4'h1;
			fsabo_subdid = 4'h2;
			fsabo_addr = FSAB_ADDR_W'(addr);
			fsabo_len = FSAB_LEN_W'(len);
			fsabo_data = d;
			fsabo_mask = m;
			for (int j = 0; j < FSAB_MASK_W; j++)
				if (m[j])
					ref_mem[addr + 8 * k + j] = d[8*j +: 8];
			@(negedge clk0_tb);
		end
		fsabo_valid = 1'b0;
	endtask

	task automatic send_read(input int addr, input int len, input int did, input int subdid);
		logic [FSAB_DATA_W-1:0] d;
		wait_credit();
		sent++;
		for (int k = 0; k < len; k++) begin
			for (int j = 0; j < FSAB_MASK_W; j++)
				d[8*j +: 8] = ref_byte(addr + 8 * k + j);
			exp_did_q.push_back(FSAB_DID_W'(did));
			exp_subdid_q.push_back(FSAB_DID_W'(subdid));
			exp_data_q.push_back(d);
			exp_first_q.push_back(k == 0);
		end
		rd_bursts_q.push_back((len + 3) / 4);   // Two beats a word, two words a burst
		fsabo_valid = 1'b1;
		fsabo_mode = FSAB_MODE_READ;
		fsabo_did = FSAB_DID_W'(did);
		fsabo_subdid = FSAB_DID_W'(subdid);
		fsabo_addr = FSAB_ADDR_W'(addr);
		fsabo_len = FSAB_LEN_W'(len);
		@(negedge clk0_tb);
		fsabo_valid = 1'b0;
	endtask

	task automatic wait_drain();
		int n;
		n = 0;
		while ((exp_head < exp_data_q.size() || credits_free() != FSAB_INITIAL_CREDITS
				|| rd_head < rd_addr_q.size()) && n < WAIT_LIMIT) begin
			@(negedge clk0_tb);
			n++;
		end
		if (n >= WAIT_LIMIT) begin
			timeouts++;
			$display("Timed out waiting for outstanding requests to finish");
		end
	endtask

	task automatic test_init_gating();
		send_write(32'h100, 4, 1'b0);
		repeat (5) @(negedge clk0_tb);
		if (cmd_count != 0) begin
			data_errors++;
			$display("Error at %0t: %0d commands before phy_init_done, expected 0",
				$time, cmd_count);
		end
		phy_init_done = 1'b1;               // About 10 cycles after reset
		send_read(32'h100, 4, 3, 5);
		wait_drain();
	endtask

	task automatic test_write_read();
		int lens [4] = '{1, 2, 5, 8};
		for (int i = 0; i < 4; i++)
			send_write(32'h1000 + 32'h100 * i, lens[i], 1'b0);
		for (int i = 0; i < 4; i++)
			send_read(32'h1000 + 32'h100 * i, lens[i], i + 4, 9 - i);
		wait_drain();
	endtask

	task automatic test_masks();
		send_write(32'h2000, 4, 1'b0);
		send_write(32'h2000, 4, 1'b1);      // Random byte enables over known data
		send_read(32'h2000, 4, 7, 1);
		wait_drain();
	endtask

	task automatic test_credits();
		int base;
		int words;
		int n;
		base = credit_pulses;
		words = wr_head + FSAB_INITIAL_CREDITS * MIG_WORDS_PER_BURST;
		for (int i = 0; i < FSAB_INITIAL_CREDITS; i++)
			send_write(32'h2800 + 32'h40 * i, 2, 1'b0);
		n = 0;
		while (wr_head < words && n < WAIT_LIMIT) begin
			@(negedge clk0_tb);
			n++;
		end
		if (wr_head < words) begin
			timeouts++;
			$display("Timed out waiting for the write words of the credit test");
		end
		@(negedge clk0_tb);                 // Credit lands one cycle after the last word
		if (credit_pulses - base != FSAB_INITIAL_CREDITS) begin
			data_errors++;
			$display("Error at %0t: %0d credit pulses for %0d requests",
				$time, credit_pulses - base, FSAB_INITIAL_CREDITS);
		end
		wait_drain();
	endtask

	task automatic test_read_order();
		for (int i = 0; i < 6; i++)
			send_read(32'h1000 + 32'h100 * (i % 4), i % 4 + 1, i, 15 - i);
		wait_drain();
	endtask

	task automatic test_stalls();
		stall_en = 1'b1;
		send_write(32'h3000, 8, 1'b0);
		send_write(32'h3100, 3, 1'b1);
		send_write(32'h3200, 6, 1'b0);
		send_read(32'h3000, 8, 2, 12);
		send_read(32'h3100, 3, 10, 6);
		send_read(32'h3200, 6, 11, 0);
		wait_drain();
		stall_en = 1'b0;
	endtask

	initial begin
		void'($urandom(32'h8189d04c));
		rst0_tb = 1'b1;
		fsabo_valid = 1'b0;
		fsabo_mode = FSAB_MODE_READ;
		fsabo_did = '0;
		fsabo_subdid = '0;
		fsabo_addr = '0;
		fsabo_len = '0;
		fsabo_data = '0;
		fsabo_mask = '0;
		app_af_afull = 1'b0;
		app_wdf_afull = 1'b0;
		rd_data_valid = 1'b0;
		rd_data_fifo_out = '0;
		phy_init_done = 1'b0;
		repeat (5) @(posedge clk0_tb);
		@(negedge clk0_tb);
		rst0_tb = 1'b0;
		test_init_gating();                 // Must run while the PHY is still in init
		test_write_read();
		test_masks();
		test_credits();
		test_read_order();
		test_stalls();
		repeat (10) @(negedge clk0_tb);
		$display("Checks done: %0d data errors, %0d protocol errors, %0d timeouts",
			data_errors, proto_errors, timeouts);
		if (data_errors + proto_errors + timeouts == 0)
			$display("Simulation finished: PASS");
		else
			$display("Simulation finished: FAIL");
		$finish;
	end

endmodule

/* tb_fsab_memory_asserts.sv */
// Concurrent checks on the bridge's top-level ports; attached to every fsab_memory by bind
`timescale 1ns/1ps

module fsab_memory_asserts (
	input logic clk0_tb,
	input logic rst0_tb,
	input logic phy_init_done,
	input logic app_af_wren,
	input logic app_af_afull,
	input logic app_wdf_wren,
	input logic app_wdf_afull,
	input logic fsabi_valid,
	input logic [fsab_mem_pkg::FSAB_DID_W-1:0] fsabi_did
);
	init_gate: assert property (@(posedge clk0_tb) disable iff (rst0_tb)
		app_af_wren |-> phy_init_done)
		else $error("Controller command issued before phy_init_done");

	cmd_stall: assert property (@(posedge clk0_tb) disable iff (rst0_tb)
		app_af_wren |-> !app_af_afull)
		else $error("Controller command issued while app_af_afull is high");

	word_stall: assert property (@(posedge clk0_tb) disable iff (rst0_tb)
		app_wdf_wren |-> !app_wdf_afull)
		else $error("Write word issued while app_wdf_afull is high");

	// One response keeps its did for all of its beats
	did_stable: assert property (@(posedge clk0_tb) disable iff (rst0_tb)
		(fsabi_valid ##1 fsabi_valid) |-> $stable(fsabi_did))
		else $error("fsabi_did changed inside a read response");
endmodule

bind fsab_memory fsab_memory_asserts fsab_memory_asserts_inst (.*);
